// ==== id_remap.f ====
+incdir+include
logic/id_remap_geom_pkg.sv
logic/id_remap_io_pkg.sv
logic/slot_allocator.sv
logic/slot_table.sv
logic/tag_restore.sv
logic/id_remap_top.sv
tb/tb_id_remap.sv

// ==== include/id_remap_params.svh ====
`ifndef ID_REMAP_PARAMS_SVH
`define ID_REMAP_PARAMS_SVH

// width of the original AXI ID as seen on ARID and RID
`define ID_REMAP_ID_WIDTH 4

// rows of the slot matrix
// each bound row belongs to one original ID while any of its columns is busy
`define ID_REMAP_NUM_ROWS 4

// columns per row
// this is how many reads one original ID may have in flight
`define ID_REMAP_NUM_COLS 4

// total capacity is NUM_ROWS times NUM_COLS outstanding reads

`endif

// ==== logic/id_remap_geom_pkg.sv ====
`default_nettype none

`include "id_remap_params.svh"

package id_remap_geom_pkg;

    // a single row or column still gets a one bit index
    localparam int row_w = (`ID_REMAP_NUM_ROWS > 1) ? $clog2(`ID_REMAP_NUM_ROWS) : 1;
    localparam int col_w = (`ID_REMAP_NUM_COLS > 1) ? $clog2(`ID_REMAP_NUM_COLS) : 1;

    // original master ID as it arrives with the request
    typedef logic [`ID_REMAP_ID_WIDTH-1:0] orig_id_t;

    // row and column index into the slot matrix
    typedef logic [row_w-1:0] row_idx_t;
    typedef logic [col_w-1:0] col_idx_t;

    // unique tag handed downstream
    // row sits in the upper bits so the tag reads as {row, col}
    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } slot_tag_t;

    // one bit per row, set while the row is bound to some ID
    typedef logic [`ID_REMAP_NUM_ROWS-1:0] row_mask_t;

    // one bit per column of a row, set while that slot is outstanding
    typedef logic [`ID_REMAP_NUM_COLS-1:0] col_mask_t;

endpackage

`default_nettype wire

// ==== logic/id_remap_io_pkg.sv ====
`default_nettype none

package id_remap_io_pkg;

    import id_remap_geom_pkg::*;

    // allocate request, a plain one cycle strobe with the ID to remap
    typedef struct packed {
        logic     valid;
        orig_id_t id;
    } alloc_req_t;

    // allocate response, combinational in the request cycle
    // tag only means something while grant is high
    typedef struct packed {
        logic      grant;
        slot_tag_t tag;
    } alloc_rsp_t;

    // free request for a tag the requester currently holds
    typedef struct packed {
        logic      valid;
        slot_tag_t tag;
    } free_req_t;

    // free response
    // id is looked up combinationally from the free tag
    // ack follows free valid one cycle later
    typedef struct packed {
        logic     ack;
        orig_id_t id;
    } free_rsp_t;

endpackage

`default_nettype wire

// ==== logic/id_remap_top.sv ====
`default_nettype none

`include "id_remap_params.svh"

module id_remap_top (
    input  logic                       clk,
    input  logic                       rst,
    input  id_remap_io_pkg::alloc_req_t alloc_req,
    output id_remap_io_pkg::alloc_rsp_t alloc_rsp,
    input  id_remap_io_pkg::free_req_t  free_req,
    output id_remap_io_pkg::free_rsp_t  free_rsp
);

    import id_remap_geom_pkg::*;

    // allocator decision for this cycle
    logic      grant;
    slot_tag_t tag;
    logic      new_row;

    // registered table state fed back to the allocator
    row_mask_t row_used;
    orig_id_t  row_ids [`ID_REMAP_NUM_ROWS];
    col_mask_t col_used [`ID_REMAP_NUM_ROWS];

    // picks the slot combinationally from the current table state
    slot_allocator allocator_i (
        .alloc_req (alloc_req),
        .row_used  (row_used),
        .row_ids   (row_ids),
        .col_used  (col_used),
        .grant     (grant),
        .tag       (tag),
        .new_row   (new_row)
    );

    // commits allocation and free at the same edge
    slot_table table_i (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .tag       (tag),
        .new_row   (new_row),
        .alloc_id  (alloc_req.id),
        .free_req  (free_req),
        .row_used  (row_used),
        .row_ids   (row_ids),
        .col_used  (col_used)
    );

    // per slot ID store for the return path
    tag_restore restore_i (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .tag       (tag),
        .alloc_id  (alloc_req.id),
        .free_req  (free_req),
        .free_rsp  (free_rsp)
    );

    // grant and tag go straight out in the request cycle
    assign alloc_rsp.grant = grant;
    assign alloc_rsp.tag   = tag;

endmodule

`default_nettype wire

// ==== logic/slot_allocator.sv ====
`default_nettype none

`include "id_remap_params.svh"

module slot_allocator (
    input  id_remap_io_pkg::alloc_req_t  alloc_req,
    input  id_remap_geom_pkg::row_mask_t row_used,
    input  id_remap_geom_pkg::orig_id_t  row_ids [`ID_REMAP_NUM_ROWS],
    input  id_remap_geom_pkg::col_mask_t col_used [`ID_REMAP_NUM_ROWS],
    output logic                         grant,
    output id_remap_geom_pkg::slot_tag_t tag,
    output logic                         new_row
);

    import id_remap_geom_pkg::*;

    // row already bound to the requested ID
    logic      hit_found;
    row_idx_t  hit_row;

    // lowest row with no binding at all
    logic      free_found;
    row_idx_t  free_row;

    // row we will allocate in and its free columns
    row_idx_t  chosen_row;
    col_mask_t free_cols;

    // lowest free column of the chosen row
    logic      col_found;
    col_idx_t  chosen_col;

    // sticky reuse
    // scan for the lowest used row whose bound ID matches the request
    always_comb begin : hit_search
        hit_found = 1'b0;
        hit_row   = '0;
        for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
            // first match wins, later rows are ignored
            if (!hit_found && row_used[r] && (row_ids[r] == alloc_req.id)) begin
                hit_found = 1'b1;
                hit_row   = row_idx_t'(r);
            end
        end
    end

    // fallback when the ID owns no row yet
    // lowest index unused row takes priority
    always_comb begin : free_row_search
        free_found = 1'b0;
        free_row   = '0;
        for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
            if (!free_found && !row_used[r]) begin
                free_found = 1'b1;
                free_row   = row_idx_t'(r);
            end
        end
    end

    // a hit row always beats a fresh row
    // keeps every read of one ID inside one row
    assign chosen_row = hit_found ? hit_row : free_row;

    // invert the used bitmap so a set bit marks a free column
    assign free_cols = ~col_used[chosen_row];

    // priority encode the lowest free column
    always_comb begin : col_search
        col_found  = 1'b0;
        chosen_col = '0;
        for (int c = 0; c < `ID_REMAP_NUM_COLS; c++) begin
            if (!col_found && free_cols[c]) begin
                col_found  = 1'b1;
                chosen_col = col_idx_t'(c);
            end
        end
    end

    // grant needs a request, a row to land in and a free column in that row
    // a full hit row refuses even if other rows are free
    assign grant = alloc_req.valid && (hit_found || free_found) && col_found;

    // tag is {row, col}, driven whether or not the grant is high
    assign tag.row = chosen_row;
    assign tag.col = chosen_col;

    // table must bind the row to the ID only when it was not a hit
    assign new_row = !hit_found;

endmodule

`default_nettype wire

// ==== logic/slot_table.sv ====
`default_nettype none

`include "id_remap_params.svh"

module slot_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          grant,
    input  id_remap_geom_pkg::slot_tag_t  tag,
    input  logic                          new_row,
    input  id_remap_geom_pkg::orig_id_t   alloc_id,
    input  id_remap_io_pkg::free_req_t    free_req,
    output id_remap_geom_pkg::row_mask_t  row_used,
    output id_remap_geom_pkg::orig_id_t   row_ids [`ID_REMAP_NUM_ROWS],
    output id_remap_geom_pkg::col_mask_t  col_used [`ID_REMAP_NUM_ROWS]
);

    import id_remap_geom_pkg::*;

    // next state of the bindings and bitmaps
    row_mask_t row_used_d;
    orig_id_t  row_ids_d [`ID_REMAP_NUM_ROWS];
    col_mask_t col_used_d [`ID_REMAP_NUM_ROWS];

    // slot addressed by the free request
    row_idx_t  rel_row;
    col_idx_t  rel_col;

    assign rel_row = free_req.tag.row;
    assign rel_col = free_req.tag.col;

    // allocation is applied first, free second
    // so a row is released only if it ends up empty after both
    always_comb begin : next_state
        // hold by default
        row_used_d = row_used;
        for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
            row_ids_d[r]  = row_ids[r];
            col_used_d[r] = col_used[r];
        end

        // allocation commit
        if (grant) begin
            // occupy the granted column
            col_used_d[tag.row][tag.col] = 1'b1;
            // a fresh row gets bound to the requesting ID
            if (new_row) begin
                row_used_d[tag.row] = 1'b1;
                row_ids_d[tag.row]  = alloc_id;
            end
        end

        // free commit
        if (free_req.valid) begin
            col_used_d[rel_row][rel_col] = 1'b0;
            // last busy column gone, row goes back to the free pool
            if (col_used_d[rel_row] == '0) begin
                row_used_d[rel_row] = 1'b0;
                row_ids_d[rel_row]  = '0;
            end
        end
    end

    // state registers
    // visible to the allocator one cycle after the commit inputs
    always_ff @(posedge clk) begin
        if (rst) begin
            // everything empty, all rows free
            row_used <= '0;
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                row_ids[r]  <= '0;
                col_used[r] <= '0;
            end
        end else begin
            row_used <= row_used_d;
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                row_ids[r]  <= row_ids_d[r];
                col_used[r] <= col_used_d[r];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tag_restore.sv ====
`default_nettype none

`include "id_remap_params.svh"

module tag_restore (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         grant,
    input  id_remap_geom_pkg::slot_tag_t tag,
    input  id_remap_geom_pkg::orig_id_t  alloc_id,
    input  id_remap_io_pkg::free_req_t   free_req,
    output id_remap_io_pkg::free_rsp_t   free_rsp
);

    import id_remap_geom_pkg::*;

    // original ID per slot, indexed [row][col]
    orig_id_t tag_mem [`ID_REMAP_NUM_ROWS][`ID_REMAP_NUM_COLS];

    // free valid delayed by one cycle
    logic     ack_q;

    // write side
    // a grant records which ID now owns the slot
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ID_REMAP_NUM_ROWS; r++) begin
                for (int c = 0; c < `ID_REMAP_NUM_COLS; c++) begin
                    tag_mem[r][c] <= '0;
                end
            end
        end else if (grant) begin
            // entries left behind by a free stay until the slot is reused
            tag_mem[tag.row][tag.col] <= alloc_id;
        end
    end

    // acknowledge is a one cycle pulse after each free
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= free_req.valid;
        end
    end

    // read side
    // restore is a plain lookup on the free tag, no valid qualification
    assign free_rsp.id  = tag_mem[free_req.tag.row][free_req.tag.col];
    assign free_rsp.ack = ack_q;

endmodule

`default_nettype wire

// ==== tb/tb_id_remap.sv ====
`default_nettype none

`include "id_remap_params.svh"

module tb_id_remap;

    import id_remap_geom_pkg::*;
    import id_remap_io_pkg::*;

    localparam int ROWS = `ID_REMAP_NUM_ROWS;
    localparam int COLS = `ID_REMAP_NUM_COLS;

    // directed table length and random phase length
    localparam int NUM_STEPS   = 27;
    localparam int RAND_CYCLES = 200;
    localparam int CYCLE_LIMIT = NUM_STEPS + RAND_CYCLES + 50;

    // operation codes of the stimulus table
    localparam logic [1:0] OP_IDLE  = 2'd0;
    localparam logic [1:0] OP_ALLOC = 2'd1;
    localparam logic [1:0] OP_FREE  = 2'd2;
    localparam logic [1:0] OP_BOTH  = 2'd3;

    // one table row
    // grant_idx counts grants in the order the model saw them
    typedef struct packed {
        logic [1:0] op;
        orig_id_t   id;
        logic [4:0] grant_idx;
    } step_t;

    logic       clk;
    logic       rst;
    alloc_req_t alloc_req;
    alloc_rsp_t alloc_rsp;
    free_req_t  free_req;
    free_rsp_t  free_rsp;

    step_t       stim_table [NUM_STEPS];
    slot_tag_t   granted_log [$];
    logic [31:0] lfsr_state;

    // reference model state
    logic        m_row_used [ROWS];
    orig_id_t    m_row_id [ROWS];
    logic [COLS-1:0] m_col [ROWS];
    orig_id_t    m_slot_id [ROWS][COLS];
    logic        prev_free_v;

    int cycle_cnt;
    int checks;
    int alloc_errs;
    int free_errs;
    int ack_errs;
    int stim_errs;

    id_remap_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .alloc_req (alloc_req),
        .alloc_rsp (alloc_rsp),
        .free_req  (free_req),
        .free_rsp  (free_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog on the cycle count
    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles without reaching the end", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // 32 bit Galois LFSR with taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        return val;
    endfunction

    // expected grant and tag from the model state before the edge
    task automatic predict_grant(input alloc_req_t req, output logic g, output slot_tag_t t);
        logic hit;
        logic row_ok;
        logic col_ok;
        int   row;
        int   col;
        hit    = 1'b0;
        row_ok = 1'b0;
        col_ok = 1'b0;
        row    = 0;
        col    = 0;
        // a row already bound to this ID comes first
        for (int r = 0; r < ROWS; r++) begin
            if (!hit && m_row_used[r] && (m_row_id[r] == req.id)) begin
                hit = 1'b1;
                row = r;
            end
        end
        // otherwise the lowest unbound row
        if (!hit) begin
            for (int r = 0; r < ROWS; r++) begin
                if (!row_ok && !m_row_used[r]) begin
                    row_ok = 1'b1;
                    row    = r;
                end
            end
        end
        if (hit || row_ok) begin
            for (int c = 0; c < COLS; c++) begin
                if (!col_ok && !m_col[row][c]) begin
                    col_ok = 1'b1;
                    col    = c;
                end
            end
        end
        g     = req.valid && col_ok;
        t.row = row_idx_t'(row);
        t.col = col_idx_t'(col);
    endtask

    // allocation first, then free
    task automatic update_model(input logic g, input slot_tag_t t, input orig_id_t id,
                                input logic free_v, input slot_tag_t ft);
        if (g) begin
            if (!m_row_used[t.row]) begin
                m_row_used[t.row] = 1'b1;
                m_row_id[t.row]   = id;
            end
            m_col[t.row][t.col]     = 1'b1;
            m_slot_id[t.row][t.col] = id;
            granted_log.push_back(t);
        end
        if (free_v) begin
            m_col[ft.row][ft.col] = 1'b0;
            // empty row goes back to the pool
            if (m_col[ft.row] == '0) begin
                m_row_used[ft.row] = 1'b0;
                m_row_id[ft.row]   = '0;
            end
        end
    endtask

    // one clock cycle of stimulus with all checks
    task automatic apply_cycle(input logic alloc_v, input orig_id_t id,
                               input logic free_v, input slot_tag_t ft);
        logic      exp_grant;
        slot_tag_t exp_tag;
        @(posedge clk);
        #1;
        // ack reflects the free of the previous cycle
        assert (free_rsp.ack == prev_free_v) else begin
            $display("ERROR %0t: free_ack is %0b, expected %0b",
                     $time, free_rsp.ack, prev_free_v);
            ack_errs++;
        end
        alloc_req.valid = alloc_v;
        alloc_req.id    = id;
        free_req.valid  = free_v;
        free_req.tag    = ft;
        predict_grant(alloc_req, exp_grant, exp_tag);
        // sample the combinational outputs mid cycle
        #4;
        assert (alloc_rsp.grant == exp_grant) else begin
            $display("ERROR %0t: grant is %0b for ID %0d, expected %0b",
                     $time, alloc_rsp.grant, id, exp_grant);
            alloc_errs++;
        end
        if (exp_grant) begin
            assert (alloc_rsp.tag == exp_tag) else begin
                $display("ERROR %0t: tag is %0h for ID %0d, expected %0h",
                         $time, alloc_rsp.tag, id, exp_tag);
                alloc_errs++;
            end
        end
        if (free_v) begin
            assert (free_rsp.id == m_slot_id[ft.row][ft.col]) else begin
                $display("ERROR %0t: restored ID is %0d for tag %0h, expected %0d",
                         $time, free_rsp.id, ft, m_slot_id[ft.row][ft.col]);
                free_errs++;
            end
        end
        update_model(exp_grant, exp_tag, id, free_v, ft);
        prev_free_v = free_v;
        checks++;
    endtask

    task automatic fill_table();
        // one ID fills row 0 from column 0 upward and is then refused
        stim_table[0]  = '{OP_ALLOC, 4'd3, 5'd0};
        stim_table[1]  = '{OP_ALLOC, 4'd3, 5'd0};
        stim_table[2]  = '{OP_ALLOC, 4'd3, 5'd0};
        stim_table[3]  = '{OP_ALLOC, 4'd3, 5'd0};
        stim_table[4]  = '{OP_ALLOC, 4'd3, 5'd0};
        // new IDs bind rows 1 to 3 while a fifth ID finds no row
        stim_table[5]  = '{OP_ALLOC, 4'd5, 5'd0};
        stim_table[6]  = '{OP_ALLOC, 4'd6, 5'd0};
        stim_table[7]  = '{OP_ALLOC, 4'd7, 5'd0};
        stim_table[8]  = '{OP_ALLOC, 4'd9, 5'd0};
        // releasing row 1 lets ID 9 in
        stim_table[9]  = '{OP_FREE,  4'd0, 5'd4};
        stim_table[10] = '{OP_IDLE,  4'd0, 5'd0};
        stim_table[11] = '{OP_ALLOC, 4'd9, 5'd0};
        stim_table[12] = '{OP_FREE,  4'd0, 5'd0};
        stim_table[13] = '{OP_ALLOC, 4'd3, 5'd0};
        // allocate and free together keep the row bound
        stim_table[14] = '{OP_BOTH,  4'd6, 5'd5};
        stim_table[15] = '{OP_ALLOC, 4'd6, 5'd0};
        stim_table[16] = '{OP_BOTH,  4'd7, 5'd6};
        stim_table[17] = '{OP_FREE,  4'd0, 5'd11};
        stim_table[18] = '{OP_ALLOC, 4'd10, 5'd0};
        // drain row 0 and hand it to a different ID
        stim_table[19] = '{OP_FREE,  4'd0, 5'd1};
        stim_table[20] = '{OP_FREE,  4'd0, 5'd2};
        stim_table[21] = '{OP_FREE,  4'd0, 5'd3};
        stim_table[22] = '{OP_FREE,  4'd0, 5'd8};
        stim_table[23] = '{OP_ALLOC, 4'd12, 5'd0};
        stim_table[24] = '{OP_ALLOC, 4'd9, 5'd0};
        stim_table[25] = '{OP_IDLE,  4'd0, 5'd0};
        stim_table[26] = '{OP_FREE,  4'd0, 5'd7};
    endtask

    initial begin : main
        slot_tag_t ft;
        logic      free_v;
        logic [1:0] op;
        orig_id_t  id;
        int        held;
        int        pick;

        rst         = 1'b1;
        alloc_req   = '0;
        free_req    = '0;
        prev_free_v = 1'b0;
        lfsr_state  = 32'h4c58_5c8a;
        checks      = 0;
        alloc_errs  = 0;
        free_errs   = 0;
        ack_errs    = 0;
        stim_errs   = 0;
        for (int r = 0; r < ROWS; r++) begin
            m_row_used[r] = 1'b0;
            m_row_id[r]   = '0;
            m_col[r]      = '0;
            for (int c = 0; c < COLS; c++) begin
                m_slot_id[r][c] = '0;
            end
        end
        fill_table();

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // directed table
        for (int i = 0; i < NUM_STEPS; i++) begin
            free_v = stim_table[i].op[1];
            ft     = '0;
            if (free_v) begin
                ft = granted_log[stim_table[i].grant_idx];
                assert (m_col[ft.row][ft.col]) else begin
                    $display("table entry %0d frees grant %0d which is not outstanding",
                             i, stim_table[i].grant_idx);
                    stim_errs++;
                    free_v = 1'b0;
                end
            end
            apply_cycle(stim_table[i].op[0], stim_table[i].id, free_v, ft);
        end

        // random phase where frees only pick held tags
        for (int i = 0; i < RAND_CYCLES; i++) begin
            op   = 2'(take_bits(2));
            id   = orig_id_t'(take_bits(3));
            held = 0;
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    held += m_col[r][c];
                end
            end
            free_v = op[1] && (held > 0);
            ft     = '0;
            if (free_v) begin
                pick = int'(take_bits(4)) % held;
                for (int r = 0; r < ROWS; r++) begin
                    for (int c = 0; c < COLS; c++) begin
                        if (m_col[r][c]) begin
                            if (pick == 0) begin
                                ft.row = row_idx_t'(r);
                                ft.col = col_idx_t'(c);
                            end
                            pick--;
                        end
                    end
                end
            end
            apply_cycle(op[0], id, free_v, ft);
        end

        // one idle cycle to see the last ack
        apply_cycle(1'b0, '0, 1'b0, '0);

        $display("checks %0d, errors: grant/tag %0d, restore %0d, ack %0d, stimulus %0d",
                 checks, alloc_errs, free_errs, ack_errs, stim_errs);
        if ((alloc_errs + free_errs + ack_errs + stim_errs) == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
